// ==== dv/boot_image.hex ====
// one 32-bit word per line; word i lands at sram 2*i (low half) and 2*i+1 (high half)
3c1d0001
8fa40004
27bd0008
00851021
ac820000
1440fffb
00000000
24084a33
3c09dead
3529beef
01095021
afaa0010
0800000c
24020fae
a1b2c3d4
5e6f7081

// ==== dv/sys_checker.sv ====
/*
 * Protocol assertions, bound into the SRAM bridge and the debug controller.
 * Inputs that a bind site does not have are tied to inactive values.
 */
`timescale 1ns/1ps

module sys_checker
    import sys_pkg::*;
    import wb_pkg::*;
(
    input logic         clk,
    input logic         i_rst,
    input wb_req_t      i_req,
    input logic         i_ack,
    input logic         i_we_n,
    input logic         i_oe_n,
    input logic         i_core_en,
    input logic         i_boot_done,
    input debug_state_e i_state
);
    int fail_count = 0;

    a_req_hold: assert property (@(posedge clk) disable iff (i_rst)
        (i_req.cyc && i_req.stb && !i_ack) |=> (i_req.stb && $stable(i_req)))
        else begin
            fail_count++;
            $error("wishbone request changed before ack");
        end

    a_ack_stb: assert property (@(posedge clk) disable iff (i_rst) i_ack |-> i_req.stb)
        else begin
            fail_count++;
            $error("ack without strobe");
        end

    a_we_oe: assert property (@(posedge clk) disable iff (i_rst) !(!i_we_n && !i_oe_n))
        else begin
            fail_count++;
            $error("we_n and oe_n low together");
        end

    // boot done must already be up and must stay up
    a_en_boot: assert property (@(posedge clk) disable iff (i_rst)
        (i_core_en || (i_state != RUN)) |-> (i_boot_done ##1 i_boot_done))
        else begin
            fail_count++;
            $error("core enabled or state left RUN before boot done, or boot done dropped");
        end
endmodule

bind wb_sram_bridge sys_checker u_bridge_checker (
    .clk(clk), .i_rst(i_rst), .i_req(i_wb_req), .i_ack(o_wb_rsp.ack),
    .i_we_n(o_sram.we_n), .i_oe_n(o_sram.oe_n), .i_core_en(1'b0),
    .i_boot_done(1'b0), .i_state(sys_pkg::RUN)
);

bind sys_ctrl sys_checker u_ctrl_checker (
    .clk(clk), .i_rst(i_rst), .i_req('0), .i_ack(1'b0), .i_we_n(1'b1), .i_oe_n(1'b1),
    .i_core_en(o_core_en), .i_boot_done(i_boot_done), .i_state(state_q)
);

// ==== dv/sys_scoreboard.sv ====
/*
 * Scoreboard for the subsystem ports.
 * Samples on the falling edge, one edge after the testbench raises i_check.
 * Decodes the digits with its own segment table; unknown patterns are errors.
 */
`timescale 1ns/1ps

module sys_scoreboard
    import sys_pkg::*;
(
    input  logic                         clk,
    input  logic                         i_rst,
    input  logic                         i_core_en,
    input  logic                         i_boot_done,
    input  logic [RDST_WIDTH-1:0]        i_ledg,
    input  logic [REDIRECT_ADDR_WIDTH:0] i_ledr,
    input  logic [SEG7_DIGITS-1:0][6:0]  i_hex,
    input  logic                         i_check,
    input  int                           i_test_id,
    input  logic                         i_exp_en,
    input  logic [RDST_WIDTH-1:0]        i_exp_ledg,
    input  logic [REDIRECT_ADDR_WIDTH:0] i_exp_ledr,
    input  logic [DATA_WIDTH-1:0]        i_exp_disp
);
    // gfedcba, lit segments as ones
    localparam logic [6:0] SEG_TABLE [16] = '{
        7'h3f, 7'h06, 7'h5b, 7'h4f, 7'h66, 7'h6d, 7'h7d, 7'h07,
        7'h7f, 7'h6f, 7'h77, 7'h7c, 7'h39, 7'h5e, 7'h79, 7'h71
    };

    logic [DATA_WIDTH-1:0] image [BOOT_WORDS];
    int error_count = 0;
    int test_count  = 0;
    int test_errs   = 0;
    bit early_seen  = 0;

    initial $readmemh(BOOT_IMAGE_FILE, image);

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("Error at %0t: %s = %h, expected %h", $time, name, got, exp);
            test_errs++;
        end
    endtask

    task automatic check_boot_word(input int i, input logic [15:0] lo, input logic [15:0] hi);
        compare($sformatf("sram[%0d]", 2 * i), {16'h0, lo}, {16'h0, image[i][15:0]});
        compare($sformatf("sram[%0d]", 2 * i + 1), {16'h0, hi}, {16'h0, image[i][31:16]});
    endtask

    task automatic close_test(input int id);
        $display("test %0d: %0s", id, (test_errs == 0) ? "ok" : "mismatch");
        error_count += test_errs;
        test_errs = 0;
        test_count++;
    endtask

    task automatic report_counts();
        $display("%0d tests run, %0d errors", test_count, error_count);
    endtask

    always @(negedge clk) begin
        logic [31:0] value;
        bit          bad;
        if (!i_rst && !i_boot_done && i_core_en && !early_seen) begin
            $display("core enable went high before the boot copy finished");
            early_seen = 1;
            error_count++;
        end
        if (i_check) begin
            value = '0;
            bad = 0;
            for (int d = 0; d < SEG7_DIGITS; d++) begin
                bad = 1;
                for (int v = 0; v < 16; v++) begin
                    if (~i_hex[d] == SEG_TABLE[v]) begin
                        value[d*4 +: 4] = 4'(v);
                        bad = 0;
                    end
                end
                if (bad) begin
                    $display("digit %0d shows a pattern that is not a hex digit", d);
                    test_errs++;
                end
            end
            compare("o_core_en", {31'h0, i_core_en}, {31'h0, i_exp_en});
            compare("o_ledg", {27'h0, i_ledg}, {27'h0, i_exp_ledg});
            compare("o_ledr", {15'h0, i_ledr}, {15'h0, i_exp_ledr});
            compare("o_hex", value, i_exp_disp);
            close_test(i_test_id);
        end
    end
endmodule

// ==== dv/tb_sys_top.sv ====
/*
 * Testbench for the boot and debug subsystem.
 * Runs from the project root so the boot image path resolves.
 * Inputs change on the falling clock edge; the scoreboard samples there too.
 */
`timescale 1ns/1ps

module sram_model
    import wb_pkg::*;
(
    input  logic                       clk,
    input  sram_pins_t                 i_pins,
    output logic [SRAM_DATA_WIDTH-1:0] o_dq
);
    logic [15:0] mem [65536];
    logic [15:0] wr_addr;
    logic [15:0] wr_data;
    logic [1:0]  wr_lanes;

    initial begin
        for (int a = 0; a < 65536; a++) begin
            mem[a] = 16'(a) ^ 16'h5a5a ^ {8'(a), 8'(a >> 8)}; // depends on all address bits
        end
    end

    // capture mid-cycle, commit when we_n rises
    always @(negedge clk) begin
        if (!i_pins.ce_n && !i_pins.we_n && i_pins.dq_oe) begin
            wr_addr  <= i_pins.addr[15:0];
            wr_data  <= i_pins.dq_out;
            wr_lanes <= {~i_pins.ub_n, ~i_pins.lb_n};
        end
    end

    always @(posedge i_pins.we_n) begin
        if (wr_lanes[0]) mem[wr_addr][7:0] = wr_data[7:0];
        if (wr_lanes[1]) mem[wr_addr][15:8] = wr_data[15:8];
    end

    assign o_dq = (!i_pins.ce_n && !i_pins.oe_n) ? mem[i_pins.addr[15:0]] : '0;
endmodule

module tb_sys_top
    import sys_pkg::*;
    import wb_pkg::*;
;
    localparam int NUM_ENTRIES = 14;
    localparam int CLK_PERIOD  = 20;

    typedef enum logic [2:0] {ACT_IDLE, ACT_KEY0, ACT_KEY1, ACT_RETIRE, ACT_TP} action_e;

    typedef struct packed {
        action_e                 act;
        retire_t                 ret;
        logic [DATA_WIDTH-1:0]   tp;
        logic                    en;
        logic [RDST_WIDTH-1:0]   ledg;
        logic [REDIRECT_ADDR_WIDTH:0] ledr;
        logic [DATA_WIDTH-1:0]   disp;
    } entry_t;

    logic clk;
    logic i_rst;
    logic [1:0] i_key;
    retire_t i_retire;
    logic [DATA_WIDTH-1:0] i_sim_tp;
    logic o_core_en;
    logic o_boot_done;
    sram_pins_t o_sram;
    logic [SRAM_DATA_WIDTH-1:0] i_sram_dq;
    logic [REDIRECT_ADDR_WIDTH:0] o_ledr;
    logic [RDST_WIDTH-1:0] o_ledg;
    logic [SEG7_DIGITS-1:0][6:0] o_hex;

    logic check;
    int   test_id;
    entry_t cur;
    entry_t stim [NUM_ENTRIES];
    logic [15:0] lfsr_q;
    retire_t r0, r1, r2, r3;

    sys_top u_sys_top (.*);

    sram_model u_sram (.clk(clk), .i_pins(o_sram), .o_dq(i_sram_dq));

    sys_scoreboard u_scoreboard (
        .clk(clk), .i_rst(i_rst), .i_core_en(o_core_en), .i_boot_done(o_boot_done),
        .i_ledg(o_ledg), .i_ledr(o_ledr), .i_hex(o_hex), .i_check(check),
        .i_test_id(test_id), .i_exp_en(cur.en), .i_exp_ledg(cur.ledg),
        .i_exp_ledr(cur.ledr), .i_exp_disp(cur.disp)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #((NUM_ENTRIES * 200 + 200) * CLK_PERIOD);
        $display("Timeout: the run did not finish within the cycle budget");
        $display("Test failed");
        $finish;
    end

    // galois lfsr, one step per bit taken
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_q[0]};
            lfsr_q = lfsr_next(lfsr_q);
        end
    endtask

    task automatic make_retire(output retire_t r);
        logic [31:0] v;
        r.en = 1'b1;
        take_bits(RDST_WIDTH, v);
        r.rdst = v[RDST_WIDTH-1:0];
        take_bits(DATA_WIDTH, v);
        r.data = v;
        take_bits(1, v);
        r.redirect = v[0];
        take_bits(REDIRECT_ADDR_WIDTH, v);
        r.redirect_addr = v[REDIRECT_ADDR_WIDTH-1:0];
    endtask

    function automatic entry_t row(action_e act, retire_t ret, logic [31:0] tp, logic en,
                                   retire_t shown, logic [31:0] disp);
        entry_t e;
        e.act  = act;
        e.ret  = ret;
        e.tp   = tp;
        e.en   = en;
        e.ledg = shown.rdst;
        e.ledr = {shown.redirect, shown.redirect_addr};
        e.disp = disp;
        return e;
    endfunction

    task automatic build_table();
        retire_t z;
        z = '0;
        stim[0]  = row(ACT_IDLE,   z,  32'h0, 1'b1, z,  32'h0);
        stim[1]  = row(ACT_RETIRE, r0, 32'h0, 1'b1, z,  32'h0); // ignored while running
        stim[2]  = row(ACT_KEY1,   z,  32'h0, 1'b1, z,  32'h0);
        stim[3]  = row(ACT_RETIRE, r1, 32'h0, 1'b0, r1, r1.data);
        stim[4]  = row(ACT_KEY0,   z,  32'h0, 1'b1, r1, r1.data);
        stim[5]  = row(ACT_RETIRE, r2, 32'h0, 1'b0, r2, r2.data);
        stim[6]  = row(ACT_KEY1,   z,  32'h0, 1'b1, r2, r2.data);
        stim[7]  = row(ACT_TP,     z,  TP_PASS_CODE, 1'b0, r2, TP_PASS_CODE);
        stim[8]  = row(ACT_TP,     z,  32'h0, 1'b0, r2, 32'h0); // clear before resuming
        stim[9]  = row(ACT_KEY1,   z,  32'h0, 1'b1, r2, 32'h0);
        stim[10] = row(ACT_TP,     z,  TP_FAIL_CODE, 1'b0, r2, TP_FAIL_CODE);
        stim[11] = row(ACT_TP,     z,  32'h0, 1'b0, r2, 32'h0);
        stim[12] = row(ACT_KEY1,   z,  32'h0, 1'b1, r2, 32'h0);
        stim[13] = row(ACT_RETIRE, r3, 32'h0, 1'b1, r2, 32'h0);
    endtask

    task automatic press_key(input int k);
        i_key[k] <= 1'b0;
        repeat (4) @(negedge clk);
        i_key[k] <= 1'b1;
        repeat (6) @(negedge clk);
    endtask

    task automatic apply_entry(input entry_t e);
        case (e.act)
            ACT_KEY0: press_key(0);
            ACT_KEY1: press_key(1);
            ACT_RETIRE: begin
                i_retire <= e.ret;
                @(negedge clk);
                i_retire <= '0;
            end
            ACT_TP:   i_sim_tp <= e.tp;
            default:  ;
        endcase
        repeat (4) @(negedge clk);
    endtask

    initial begin
        i_rst = 1'b1;
        i_key = 2'b11;
        i_retire = '0;
        i_sim_tp = '0;
        check = 1'b0;
        test_id = 0;
        cur = '0;
        lfsr_q = 16'd18928;
        make_retire(r0);
        make_retire(r1);
        make_retire(r2);
        make_retire(r3);
        build_table();
        repeat (4) @(negedge clk);
        i_rst <= 1'b0;
        while (!o_boot_done) @(negedge clk);
        repeat (2) @(negedge clk);
        for (int i = 0; i < BOOT_WORDS; i++) begin
            u_scoreboard.check_boot_word(i, u_sram.mem[2 * i], u_sram.mem[2 * i + 1]);
        end
        u_scoreboard.close_test(0);
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            apply_entry(stim[i]);
            cur <= stim[i];
            test_id <= i + 1;
            check <= 1'b1;
            @(negedge clk);
            check <= 1'b0;
        end
        @(negedge clk);
        u_scoreboard.report_counts();
        if ((u_scoreboard.error_count == 0)
                && (u_sys_top.u_wb_sram_bridge.u_bridge_checker.fail_count == 0)
                && (u_sys_top.u_sys_ctrl.u_ctrl_checker.fail_count == 0)) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end
endmodule

// ==== hdl/boot_copier.sv ====
/*
 * Copies the boot image from a small ROM into SRAM over Wishbone.
 * Word i goes to byte address 4*i as a full-width write; one request is
 * outstanding at a time. The copy starts right after reset and runs once.
 * o_boot_done stays high until the next reset.
 */
`timescale 1ns/1ps

module boot_copier
    import sys_pkg::*;
    import wb_pkg::*;
(
    input  logic    clk,
    input  logic    i_rst,
    output wb_req_t o_wb_req,
    input  wb_rsp_t i_wb_rsp,
    output logic    o_boot_done
);

    logic [WB_DATA_WIDTH-1:0] rom [BOOT_WORDS];

    logic [BOOT_IDX_WIDTH-1:0] idx_q;
    logic                      busy_q;
    logic                      done_q;
    logic                      last_word;

    initial begin
        $readmemh(BOOT_IMAGE_FILE, rom);
    end

    assign last_word = (idx_q == BOOT_IDX_WIDTH'(BOOT_WORDS - 1));

    // idle is !busy && !done, strobing is busy, finished is done
    always_ff @(posedge clk) begin
        if (i_rst) begin
            idx_q  <= '0;
            busy_q <= 1'b0;
            done_q <= 1'b0;
        end else if (!busy_q && !done_q) begin
            busy_q <= 1'b1;
        end else if (busy_q && i_wb_rsp.ack) begin
            if (last_word) begin
                busy_q <= 1'b0;
                done_q <= 1'b1;
            end else begin
                idx_q <= idx_q + 1'b1; // strobe stays up and the next word follows at once
            end
        end
    end

    always_comb begin
        o_wb_req.cyc  = busy_q;
        o_wb_req.stb  = busy_q;
        o_wb_req.we   = 1'b1;
        o_wb_req.cti  = last_word ? END : INCR;
        o_wb_req.bte  = '0; // linear burst
        o_wb_req.sel  = '1;
        o_wb_req.addr = WB_ADDR_WIDTH'({idx_q, 2'b00});
        o_wb_req.data = rom[idx_q];
    end

    assign o_boot_done = done_q;

endmodule

// ==== hdl/seg7_display.sv ====
/*
 * Hex display driver for eight seven-segment digits.
 * Outputs are active low with segment a on bit 0; digit 0 shows the lowest
 * nibble. Purely combinational.
 */
`timescale 1ns/1ps

module seg7_display
    import sys_pkg::*;
(
    input  logic [DATA_WIDTH-1:0]             i_value,
    output logic [SEG7_DIGITS-1:0][6:0]       o_hex
);

    // active-high pattern, gfedcba
    function automatic logic [6:0] seg_pattern(input logic [3:0] nibble);
        case (nibble)
            4'h0:    return 7'h3f;
            4'h1:    return 7'h06;
            4'h2:    return 7'h5b;
            4'h3:    return 7'h4f;
            4'h4:    return 7'h66;
            4'h5:    return 7'h6d;
            4'h6:    return 7'h7d;
            4'h7:    return 7'h07;
            4'h8:    return 7'h7f;
            4'h9:    return 7'h6f;
            4'ha:    return 7'h77;
            4'hb:    return 7'h7c;
            4'hc:    return 7'h39;
            4'hd:    return 7'h5e;
            4'he:    return 7'h79;
            default: return 7'h71;
        endcase
    endfunction

    for (genvar d = 0; d < SEG7_DIGITS; d++) begin : g_digit
        assign o_hex[d] = ~seg_pattern(i_value[d*4 +: 4]);
    end

endmodule

// ==== hdl/sys_ctrl.sv ====
/*
 * Debug controller for the core: run, single step, halt and test done.
 * Buttons are active low and asynchronous; a press is seen 3 clocks later.
 * The core must stop retiring while o_core_en is low, since retirements
 * arriving outside STEP are not latched.
 */
`timescale 1ns/1ps

module sys_ctrl
    import sys_pkg::*;
(
    input  logic                           clk,
    input  logic                           i_rst,
    input  logic [1:0]                     i_key,
    input  logic                           i_boot_done,
    input  retire_t                        i_retire,
    input  logic [DATA_WIDTH-1:0]          i_sim_tp,
    output logic                           o_core_en,
    output logic [REDIRECT_ADDR_WIDTH:0]   o_ledr,
    output logic [RDST_WIDTH-1:0]          o_ledg,
    output logic [DATA_WIDTH-1:0]          o_disp_data
);

    logic [1:0] key_meta_q;
    logic [1:0] key_sync_q;
    logic [1:0] key_prev_q;
    logic [1:0] key_pulse;

    debug_state_e state_q;
    debug_state_e state_d;

    logic tp_hit;
    logic step_retire;

    logic                           redirect_q;
    logic [REDIRECT_ADDR_WIDTH-1:0] redirect_addr_q;
    logic [RDST_WIDTH-1:0]          rdst_q;
    logic [DATA_WIDTH-1:0]          data_q;

    always_ff @(posedge clk) begin
        if (i_rst) begin
            key_meta_q <= '0;
            key_sync_q <= '0;
            key_prev_q <= '0;
        end else begin
            key_meta_q <= ~i_key; // pressed reads as 1 from here on
            key_sync_q <= key_meta_q;
            key_prev_q <= key_sync_q;
        end
    end

    assign key_pulse = key_sync_q & ~key_prev_q;

    assign tp_hit = (i_sim_tp == TP_PASS_CODE) || (i_sim_tp == TP_FAIL_CODE);
    assign step_retire = (state_q == STEP) && i_retire.en;

    always_comb begin
        unique case (state_q)
            RUN:     state_d = tp_hit ? DONE : (key_pulse[1] ? STEP : RUN);
            STEP:    state_d = i_retire.en ? HALT : STEP;
            HALT:    state_d = key_pulse[1] ? RUN : (key_pulse[0] ? STEP : HALT);
            DONE:    state_d = key_pulse[1] ? RUN : (key_pulse[0] ? STEP : DONE);
            default: state_d = RUN;
        endcase
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            state_q <= RUN;
        end else if (i_boot_done) begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            redirect_q      <= 1'b0;
            redirect_addr_q <= '0;
            rdst_q          <= '0;
            data_q          <= '0;
        end else begin
            if (step_retire) begin
                redirect_q      <= i_retire.redirect;
                redirect_addr_q <= i_retire.redirect_addr;
                rdst_q          <= i_retire.rdst;
                data_q          <= i_retire.data;
            end else if (state_q == DONE) begin
                data_q <= i_sim_tp; // digits follow the test point once finished
            end
        end
    end

    assign o_core_en   = i_boot_done && ((state_q == RUN) || (state_q == STEP));
    assign o_ledr      = {redirect_q, redirect_addr_q};
    assign o_ledg      = rdst_q;
    assign o_disp_data = data_q;

endmodule

// ==== hdl/sys_pkg.sv ====
/*
 * System constants, debug states and the retirement event record.
 * BOOT_IMAGE_FILE is relative to the simulator's working directory and must
 * hold exactly BOOT_WORDS hex words. Only the low REDIRECT_ADDR_WIDTH bits of a
 * redirect address are kept, since that is all the LEDs can show.
 */
package sys_pkg;

    localparam int DATA_WIDTH          = 32;
    localparam int RDST_WIDTH          = 5;
    localparam int REDIRECT_ADDR_WIDTH = 16;
    localparam int SEG7_DIGITS         = 8;

    localparam int    BOOT_WORDS      = 16;
    localparam int    BOOT_IDX_WIDTH  = $clog2(BOOT_WORDS);
    localparam string BOOT_IMAGE_FILE = "dv/boot_image.hex";

    // test point values written by the test program when it finishes
    localparam logic [DATA_WIDTH-1:0] TP_PASS_CODE = 32'h0000_4a33;
    localparam logic [DATA_WIDTH-1:0] TP_FAIL_CODE = 32'h0000_fae1;

    typedef enum logic [1:0] {
        RUN,
        STEP,
        HALT,
        DONE
    } debug_state_e;

    // one retirement as reported by the core, valid when en is set
    typedef struct packed {
        logic                           en;
        logic [RDST_WIDTH-1:0]          rdst;
        logic [DATA_WIDTH-1:0]          data;
        logic                           redirect;
        logic [REDIRECT_ADDR_WIDTH-1:0] redirect_addr;
    } retire_t;

endpackage

// ==== hdl/sys_top.sv ====
/*
 * Boot and debug subsystem top level.
 * The core itself sits outside: it reports retirements and its test point
 * here and must only advance while o_core_en is high. Only the boot copier
 * masters the SRAM bridge. SRAM data is split into in and out buses.
 */
`timescale 1ns/1ps

module sys_top
    import sys_pkg::*;
    import wb_pkg::*;
(
    input  logic                           clk,
    input  logic                           i_rst,
    input  logic [1:0]                     i_key,
    input  retire_t                        i_retire,
    input  logic [DATA_WIDTH-1:0]          i_sim_tp,
    output logic                           o_core_en,
    output logic                           o_boot_done,
    output sram_pins_t                     o_sram,
    input  logic [SRAM_DATA_WIDTH-1:0]     i_sram_dq,
    output logic [REDIRECT_ADDR_WIDTH:0]   o_ledr,
    output logic [RDST_WIDTH-1:0]          o_ledg,
    output logic [SEG7_DIGITS-1:0][6:0]    o_hex
);

    wb_req_t                wb_req;
    wb_rsp_t                wb_rsp;
    logic [DATA_WIDTH-1:0]  disp_data;

    sys_ctrl u_sys_ctrl (
        .clk         (clk),
        .i_rst       (i_rst),
        .i_key       (i_key),
        .i_boot_done (o_boot_done),
        .i_retire    (i_retire),
        .i_sim_tp    (i_sim_tp),
        .o_core_en   (o_core_en),
        .o_ledr      (o_ledr),
        .o_ledg      (o_ledg),
        .o_disp_data (disp_data)
    );

    boot_copier u_boot_copier (
        .clk         (clk),
        .i_rst       (i_rst),
        .o_wb_req    (wb_req),
        .i_wb_rsp    (wb_rsp),
        .o_boot_done (o_boot_done)
    );

    wb_sram_bridge u_wb_sram_bridge (
        .clk       (clk),
        .i_rst     (i_rst),
        .i_wb_req  (wb_req),
        .o_wb_rsp  (wb_rsp),
        .o_sram    (o_sram),
        .i_sram_dq (i_sram_dq)
    );

    seg7_display u_seg7_display (
        .i_value (disp_data),
        .o_hex   (o_hex)
    );

endmodule

// ==== hdl/wb_pkg.sv ====
/*
 * Wishbone and SRAM pin bundles for the boot path.
 * The SRAM data bus is split into dq_out and a separate read bus plus dq_oe;
 * the board level is expected to build the tri-state from these.
 */
package wb_pkg;

    localparam int WB_ADDR_WIDTH   = 32;
    localparam int WB_DATA_WIDTH   = 32;
    localparam int WB_SEL_WIDTH    = WB_DATA_WIDTH / 8;
    localparam int WB_CTI_WIDTH    = 3;
    localparam int WB_BTE_WIDTH    = 2;
    localparam int SRAM_ADDR_WIDTH = 20;
    localparam int SRAM_DATA_WIDTH = 16;

    typedef enum logic [WB_CTI_WIDTH-1:0] {
        CLASSIC = 3'b000,
        INCR    = 3'b010,
        END     = 3'b111
    } wb_cti_e;

    typedef struct packed {
        logic                     cyc;
        logic                     stb;
        logic                     we;
        wb_cti_e                  cti;
        logic [WB_BTE_WIDTH-1:0]  bte;
        logic [WB_SEL_WIDTH-1:0]  sel;
        logic [WB_ADDR_WIDTH-1:0] addr;
        logic [WB_DATA_WIDTH-1:0] data;
    } wb_req_t;

    typedef struct packed {
        logic                     ack;
        logic [WB_DATA_WIDTH-1:0] data;
    } wb_rsp_t;

    typedef struct packed {
        logic                       ce_n;
        logic                       oe_n;
        logic                       we_n;
        logic                       lb_n;
        logic                       ub_n;
        logic [SRAM_ADDR_WIDTH-1:0] addr;
        logic [SRAM_DATA_WIDTH-1:0] dq_out;
        logic                       dq_oe;
    } sram_pins_t;

endpackage

// ==== hdl/wb_sram_bridge.sv ====
/*
 * Wishbone slave in front of a 16-bit asynchronous SRAM.
 * Each 32-bit access becomes two half-word cycles, low half at SRAM address
 * 2*i and high half at 2*i+1, and is acked exactly 4 clocks after the first
 * cycle with cyc and stb high. Burst type fields are ignored, so every
 * access is handled as a classic cycle. The request must stay stable until ack.
 */
`timescale 1ns/1ps

module wb_sram_bridge
    import wb_pkg::*;
(
    input  logic                       clk,
    input  logic                       i_rst,
    input  wb_req_t                    i_wb_req,
    output wb_rsp_t                    o_wb_rsp,
    output sram_pins_t                 o_sram,
    input  logic [SRAM_DATA_WIDTH-1:0] i_sram_dq
);

    typedef enum logic [2:0] {
        PH_IDLE,
        PH_LO_SETUP,
        PH_LO_STROBE,
        PH_HI_SETUP,
        PH_HI_STROBE
    } phase_e;

    phase_e phase_q;
    phase_e phase_d;

    logic [SRAM_DATA_WIDTH-1:0] rd_lo_q;
    logic                       active;
    logic                       hi_half;
    logic                       strobe;
    logic [1:0]                 half_sel;

    always_comb begin
        unique case (phase_q)
            PH_IDLE:      phase_d = (i_wb_req.cyc && i_wb_req.stb) ? PH_LO_SETUP : PH_IDLE;
            PH_LO_SETUP:  phase_d = PH_LO_STROBE;
            PH_LO_STROBE: phase_d = PH_HI_SETUP;
            PH_HI_SETUP:  phase_d = PH_HI_STROBE;
            PH_HI_STROBE: phase_d = PH_IDLE;
            default:      phase_d = PH_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            phase_q <= PH_IDLE;
        end else begin
            phase_q <= phase_d;
        end
    end

    // low half of a read is parked here until the high half arrives
    always_ff @(posedge clk) begin
        if ((phase_q == PH_LO_STROBE) && !i_wb_req.we) begin
            rd_lo_q <= i_sram_dq;
        end
    end

    assign active   = (phase_q != PH_IDLE);
    assign hi_half  = (phase_q == PH_HI_SETUP) || (phase_q == PH_HI_STROBE);
    assign strobe   = (phase_q == PH_LO_STROBE) || (phase_q == PH_HI_STROBE);
    assign half_sel = hi_half ? i_wb_req.sel[3:2] : i_wb_req.sel[1:0];

    always_comb begin
        o_sram.ce_n   = ~active;
        o_sram.oe_n   = ~(active && !i_wb_req.we);
        o_sram.we_n   = ~(strobe && i_wb_req.we); // setup phases keep we_n high
        o_sram.lb_n   = ~(active && half_sel[0]);
        o_sram.ub_n   = ~(active && half_sel[1]);
        o_sram.addr   = {i_wb_req.addr[SRAM_ADDR_WIDTH:2], hi_half};
        o_sram.dq_out = hi_half ? i_wb_req.data[WB_DATA_WIDTH-1:SRAM_DATA_WIDTH]
                                : i_wb_req.data[SRAM_DATA_WIDTH-1:0];
        o_sram.dq_oe  = active && i_wb_req.we;
    end

    always_comb begin
        o_wb_rsp.ack  = (phase_q == PH_HI_STROBE);
        o_wb_rsp.data = {i_sram_dq, rd_lo_q}; // valid only with ack on a read
    end

endmodule

// ==== run.sh ====
#!/bin/sh
# Build and run the testbench with Verilator from the project root.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_sys_top -f tb.f -o sim_tb > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
    cat build.log
    echo "build failed with status $status"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Test failed" sim.log; then
    exit 1
fi
exit 0

// ==== tb.f ====
hdl/sys_pkg.sv
hdl/wb_pkg.sv
hdl/sys_ctrl.sv
hdl/boot_copier.sv
hdl/wb_sram_bridge.sv
hdl/seg7_display.sv
hdl/sys_top.sv
dv/sys_checker.sv
dv/sys_scoreboard.sv
dv/tb_sys_top.sv
